// File: gfx_pkg.sv
// ================================================
// graphics definitions for the pixel plot unit
// colour depth codes, display setup, plot commands
// and the strip address record between stages
// ================================================
`default_nettype none

package gfx_pkg;

	// ================================================
	// colour depth
	// ================================================
	// pixels per 128-bit strip in code order
	// 21, 16, 14, 10, 8, 8, 5, 4
	typedef enum logic [2:0] {
		BPP6  = 3'd0,
		BPP8  = 3'd1,
		BPP9  = 3'd2,
		BPP12 = 3'd3,
		BPP15 = 3'd4,
		BPP16 = 3'd5,
		BPP24 = 3'd6,
		BPP32 = 3'd7
	} color_depth_e;

	// ================================================
	// display configuration and commands
	// ================================================
	// static while commands are in flight
	typedef struct packed {
		logic [31:0]  base_address;
		color_depth_e color_depth;
		// pixels per line
		logic [11:0]  hdisplayed;
		// number of lines
		logic [11:0]  vdisplayed;
	} disp_cfg_t;

	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
		logic [31:0] color;
	} plot_cmd_t;

	// byte address of the strip, pixel bit range mb..me, colour
	typedef struct packed {
		logic [31:0] addr;
		logic [6:0]  mb;
		logic [6:0]  me;
		logic [31:0] color;
	} addr_info_t;

endpackage

`default_nettype wire

// File: mem_pkg.sv
// ================================================
// frame buffer memory port definitions
// one strip per write, bit mask selects the pixel
// ================================================
`default_nettype none

package mem_pkg;

	// width of one memory strip in bits
	localparam int STRIP_BITS = 128;

	// masked strip write
	// only bits with mask set are written
	typedef struct packed {
		logic [31:0]           addr;
		logic [STRIP_BITS-1:0] data;
		logic [STRIP_BITS-1:0] mask;
	} strip_wr_t;

endpackage

`default_nettype wire

// File: gfx_clip_stage.sv
// ================================================
// plot command clip stage
// registers commands inside the displayed area and
// counts the ones that fall outside it
// ================================================
`timescale 1ns/1ps
`default_nettype none

module gfx_clip_stage #(
	parameter int COUNT_W = 8
) (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  gfx_pkg::disp_cfg_t  cfg_i,
	input  logic                plot_i,
	input  gfx_pkg::plot_cmd_t  cmd_i,
	output logic                valid_o,
	output gfx_pkg::plot_cmd_t  cmd_o,
	output logic [COUNT_W-1:0]  drop_count_o
);

	logic in_area;
	logic drop;

	// both coordinates must be below the displayed size
	assign in_area = (cmd_i.x < cfg_i.hdisplayed) && (cmd_i.y < cfg_i.vdisplayed);
	assign drop    = plot_i && !in_area;

	// ================================================
	// control
	// ================================================
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			// one cycle strobe, only for visible pixels
			valid_o <= plot_i && in_area;
		end
	end

	// drop counter sticks at all ones
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			drop_count_o <= '0;
		end else if (drop && (drop_count_o != {COUNT_W{1'b1}})) begin
			drop_count_o <= drop_count_o + 1'b1;
		end
	end

	// ================================================
	// payload
	// ================================================
	// command is captured on every accepted strobe
	always_ff @(posedge clk_i) begin
		if (plot_i) begin
			cmd_o <= cmd_i;
		end
	end

endmodule

`default_nettype wire

// File: gfx_calc_address.sv
// ================================================
// strip address calculation
// finds the strip holding pixel x,y and the bit
// range of the pixel inside that strip
// ================================================
`timescale 1ns/1ps
`default_nettype none

module gfx_calc_address (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  gfx_pkg::disp_cfg_t  cfg_i,
	input  logic                valid_i,
	input  gfx_pkg::plot_cmd_t  cmd_i,
	output logic                valid_o,
	output gfx_pkg::addr_info_t info_o
);

	// per depth constants
	logic [15:0] coeff;
	logic [5:0]  bits;
	logic [4:0]  pps;

	logic [12:0] strip_idx;
	logic [12:0] strips_per_line;
	logic [12:0] x_rem;
	logic [6:0]  mb;
	logic [6:0]  me;
	logic [31:0] strip_num;
	logic [31:0] strip_addr;

	// divide by pixels per strip using the 16 bit reciprocal
	// reciprocal is rounded down so the estimate is exact or one low
	// one compare on the remainder brings it to the true quotient
	function automatic logic [12:0] recip_div(
		input logic [12:0] num,
		input logic [15:0] recip,
		input logic [4:0]  div
	);
		logic [28:0] prod;
		logic [12:0] quo;
		logic [12:0] rem;
		prod = num * recip;
		quo  = prod[28:16];
		rem  = num - quo * 13'(div);
		if (rem >= 13'(div)) begin
			quo = quo + 13'd1;
		end
		return quo;
	endfunction

	// ================================================
	// depth tables
	// ================================================
	// coeff is floor(65536 / pixels per strip)
	always_comb begin
		case (cfg_i.color_depth)
			gfx_pkg::BPP6:  begin coeff = 16'd3120;  bits = 6'd6;  pps = 5'd21; end
			gfx_pkg::BPP8:  begin coeff = 16'd4096;  bits = 6'd8;  pps = 5'd16; end
			gfx_pkg::BPP9:  begin coeff = 16'd4681;  bits = 6'd9;  pps = 5'd14; end
			gfx_pkg::BPP12: begin coeff = 16'd6553;  bits = 6'd12; pps = 5'd10; end
			gfx_pkg::BPP15: begin coeff = 16'd8192;  bits = 6'd15; pps = 5'd8;  end
			gfx_pkg::BPP16: begin coeff = 16'd8192;  bits = 6'd16; pps = 5'd8;  end
			gfx_pkg::BPP24: begin coeff = 16'd13107; bits = 6'd24; pps = 5'd5;  end
			default:        begin coeff = 16'd16384; bits = 6'd32; pps = 5'd4;  end
		endcase
	end

	// ================================================
	// strip index, bit range and address
	// ================================================
	always_comb begin
		strip_idx = recip_div({1'b0, cmd_i.x}, coeff, pps);
		// round up so a partly used last strip still counts
		strips_per_line = recip_div({1'b0, cfg_i.hdisplayed} + 13'(pps) - 13'd1, coeff, pps);
		// pixel position inside its strip, always below pps
		x_rem = {1'b0, cmd_i.x} - strip_idx * 13'(pps);
		mb    = 7'(x_rem * 13'(bits));
		me    = mb + 7'(bits) - 7'd1;
		// strips from the start of the frame
		strip_num  = 32'(strips_per_line) * 32'(cmd_i.y) + 32'(strip_idx);
		// 16 bytes per strip
		strip_addr = cfg_i.base_address + {strip_num[27:0], 4'h0};
	end

	// ================================================
	// output registers
	// ================================================
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			info_o.addr  <= strip_addr;
			info_o.mb    <= mb;
			info_o.me    <= me;
			info_o.color <= cmd_i.color;
		end
	end

endmodule

`default_nettype wire

// File: gfx_strip_writer.sv
// ================================================
// strip writer
// shifts the colour to the pixel position and
// issues one masked strip write per pixel
// ================================================
`timescale 1ns/1ps
`default_nettype none

module gfx_strip_writer (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                valid_i,
	input  gfx_pkg::addr_info_t info_i,
	output logic                mem_we_o,
	output mem_pkg::strip_wr_t  mem_wr_o
);

	localparam int SB = mem_pkg::STRIP_BITS;
	localparam logic [SB-1:0] ONES = {SB{1'b1}};

	logic [SB-1:0] mask_lo;
	logic [SB-1:0] mask_hi;
	logic [SB-1:0] mask;
	logic [SB-1:0] color_wide;
	logic [SB-1:0] data;

	// ================================================
	// mask and data
	// ================================================
	// ones from mb upward
	assign mask_lo = ONES << info_i.mb;
	// ones from me downward
	assign mask_hi = ONES >> (7'(SB - 1) - info_i.me);
	assign mask    = mask_lo & mask_hi;

	// colour zero extended to the strip width
	assign color_wide = {{(SB - 32){1'b0}}, info_i.color};

	// colour lands at mb
	// masking drops the bits above the pixel width
	// so a wide colour cannot spill into the next pixel
	assign data = (color_wide << info_i.mb) & mask;

	// ================================================
	// write port registers
	// ================================================
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_we_o <= 1'b0;
		end else begin
			// single cycle write strobe
			mem_we_o <= valid_i;
		end
	end

	// write record held until the next pixel arrives
	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			mem_wr_o.addr <= info_i.addr;
			mem_wr_o.data <= data;
			mem_wr_o.mask <= mask;
		end
	end

endmodule

`default_nettype wire

// File: gfx_plot_unit.sv
// ================================================
// pixel plot unit top level
// clip, address and write stages, three cycles from
// plot strobe to masked strip write
// ================================================
`timescale 1ns/1ps
`default_nettype none

module gfx_plot_unit #(
	parameter int COUNT_W = 8
) (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  gfx_pkg::disp_cfg_t  cfg_i,
	input  logic                plot_i,
	input  gfx_pkg::plot_cmd_t  cmd_i,
	output logic                mem_we_o,
	output mem_pkg::strip_wr_t  mem_wr_o,
	output logic [COUNT_W-1:0]  drop_count_o
);

	// clip to address stage
	logic               clip_valid;
	gfx_pkg::plot_cmd_t clip_cmd;

	// address to writer stage
	logic                addr_valid;
	gfx_pkg::addr_info_t addr_info;

	// ================================================
	// stage 1, area check and drop count
	// ================================================
	gfx_clip_stage #(
		.COUNT_W(COUNT_W)
	) u_clip (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.cfg_i       (cfg_i),
		.plot_i      (plot_i),
		.cmd_i       (cmd_i),
		.valid_o     (clip_valid),
		.cmd_o       (clip_cmd),
		.drop_count_o(drop_count_o)
	);

	// stage 2, strip address and bit range
	gfx_calc_address u_calc (
		.clk_i  (clk_i),
		.rst_n_i(rst_n_i),
		.cfg_i  (cfg_i),
		.valid_i(clip_valid),
		.cmd_i  (clip_cmd),
		.valid_o(addr_valid),
		.info_o (addr_info)
	);

	// stage 3, masked write to memory
	gfx_strip_writer u_writer (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.valid_i (addr_valid),
		.info_i  (addr_info),
		.mem_we_o(mem_we_o),
		.mem_wr_o(mem_wr_o)
	);

endmodule

`default_nettype wire

// File: tb_plot_checker.sv
// ================================================
// plot unit write checker
// queues expected strip writes at each plot strobe
// and compares them with the memory port three
// cycles later, tracks the drop counter as well
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tb_plot_checker #(
	parameter int COUNT_W = 8
) (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               plot_i,
	input  logic               exp_drop_i,
	input  mem_pkg::strip_wr_t exp_wr_i,
	input  logic               mem_we_i,
	input  mem_pkg::strip_wr_t mem_wr_i,
	input  logic [COUNT_W-1:0] drop_count_i,
	output logic               idle_o,
	output int                 err_count_o,
	output int                 write_count_o,
	output int                 drop_total_o
);

	// writes in flight with the cycle each one is due
	mem_pkg::strip_wr_t wr_q[$];
	int                 due_q[$];
	int                 cyc;

	task automatic compare_field(
		input string        name,
		input logic [127:0] exp_val,
		input logic [127:0] act_val
	);
		if (exp_val !== act_val) begin
			$display("MISMATCH %s expected %0h actual %0h", name, exp_val, act_val);
			err_count_o++;
		end
	endtask

	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			cyc           = 0;
			err_count_o   = 0;
			write_count_o = 0;
			drop_total_o  = 0;
			wr_q.delete();
			due_q.delete();
		end else begin
			// ================================================
			// drop counter, one edge behind the strobe
			// ================================================
			if (drop_count_i !== COUNT_W'(drop_total_o)) begin
				$display("MISMATCH drop_count_o expected %0h actual %0h",
					COUNT_W'(drop_total_o), drop_count_i);
				err_count_o++;
			end
			// due date passed without a write
			while (due_q.size() > 0 && due_q[0] < cyc) begin
				$display("expected write to address %0h never arrived (due at cycle %0d)",
					wr_q[0].addr, due_q[0]);
				err_count_o++;
				void'(wr_q.pop_front());
				void'(due_q.pop_front());
			end
			// ================================================
			// memory port
			// ================================================
			if (mem_we_i) begin
				if (due_q.size() == 0 || due_q[0] != cyc) begin
					$display("write to address %0h at cycle %0d was not expected",
						mem_wr_i.addr, cyc);
					err_count_o++;
				end else begin
					compare_field("mem_wr_o.addr", 128'(wr_q[0].addr), 128'(mem_wr_i.addr));
					compare_field("mem_wr_o.data", wr_q[0].data, mem_wr_i.data);
					compare_field("mem_wr_o.mask", wr_q[0].mask, mem_wr_i.mask);
					void'(wr_q.pop_front());
					void'(due_q.pop_front());
					write_count_o++;
				end
			end
			// new command seen by the DUT on this edge
			if (plot_i) begin
				if (exp_drop_i) begin
					drop_total_o++;
				end else begin
					wr_q.push_back(exp_wr_i);
					due_q.push_back(cyc + 3);
				end
			end
			cyc++;
		end
		idle_o = (due_q.size() == 0);
	end

endmodule

`default_nettype wire

// File: tb_gfx_plot_unit.sv
// ================================================
// pixel plot unit testbench
// reads commands and expected results from the
// stimulus file and drives them into the DUT
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_plot_unit;

	localparam int COUNT_W   = 8;
	localparam int FIELDS    = 10;
	localparam int MAX_LINES = 64;

	logic                clk;
	logic                rst_n;
	gfx_pkg::disp_cfg_t  cfg;
	logic                plot;
	gfx_pkg::plot_cmd_t  cmd;
	logic                mem_we;
	mem_pkg::strip_wr_t  mem_wr;
	logic [COUNT_W-1:0]  drop_count;
	mem_pkg::strip_wr_t  exp_wr;
	logic                exp_drop;
	logic                idle;
	int                  err_count;
	int                  write_count;
	int                  drop_total;

	// one word per column and FIELDS words per command
	logic [31:0] stim_mem [0:MAX_LINES*FIELDS-1];
	int          n_lines;
	int          cycles = 0;
	int          cycle_limit = 1000000;

	gfx_plot_unit #(
		.COUNT_W(COUNT_W)
	) dut_i (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.cfg_i       (cfg),
		.plot_i      (plot),
		.cmd_i       (cmd),
		.mem_we_o    (mem_we),
		.mem_wr_o    (mem_wr),
		.drop_count_o(drop_count)
	);

	tb_plot_checker #(
		.COUNT_W(COUNT_W)
	) u_check (
		.clk_i        (clk),
		.rst_n_i      (rst_n),
		.plot_i       (plot),
		.exp_drop_i   (exp_drop),
		.exp_wr_i     (exp_wr),
		.mem_we_i     (mem_we),
		.mem_wr_i     (mem_wr),
		.drop_count_i (drop_count),
		.idle_o       (idle),
		.err_count_o  (err_count),
		.write_count_o(write_count),
		.drop_total_o (drop_total)
	);

	always #4 clk = ~clk;

	// bits per pixel for each depth code
	function automatic int depth_bits(input logic [2:0] code);
		case (code)
			3'd0:    return 6;
			3'd1:    return 8;
			3'd2:    return 9;
			3'd3:    return 12;
			3'd4:    return 15;
			3'd5:    return 16;
			3'd6:    return 24;
			default: return 32;
		endcase
	endfunction

	// ones at mb .. mb+nbits-1 in mask and colour low bits there in data
	function automatic mem_pkg::strip_wr_t build_write(
		input logic [31:0] addr,
		input int          mb,
		input int          nbits,
		input logic [31:0] color
	);
		mem_pkg::strip_wr_t wr;
		int i;
		wr      = '0;
		wr.addr = addr;
		for (i = 0; i < nbits; i++) begin
			wr.mask[mb+i] = 1'b1;
			wr.data[mb+i] = color[i];
		end
		return wr;
	endfunction

	// ================================================
	// driver
	// ================================================
	task automatic apply_line(input int ln);
		gfx_pkg::disp_cfg_t new_cfg;
		int                 base;
		int                 gap;
		base                 = ln * FIELDS;
		new_cfg.base_address = stim_mem[base];
		new_cfg.color_depth  = gfx_pkg::color_depth_e'(stim_mem[base+1][2:0]);
		new_cfg.hdisplayed   = stim_mem[base+2][11:0];
		new_cfg.vdisplayed   = stim_mem[base+3][11:0];
		// a new display setup waits for an empty pipe plus a random idle gap
		// commands under the same setup run back to back
		if (new_cfg != cfg) begin
			gap = 3 + int'($urandom % 4);
			repeat (gap) @(posedge clk);
			#1;
			cfg = new_cfg;
		end
		cmd.x     = stim_mem[base+4][11:0];
		cmd.y     = stim_mem[base+5][11:0];
		cmd.color = stim_mem[base+6];
		exp_drop  = stim_mem[base+9][0];
		exp_wr    = build_write(stim_mem[base+7], int'(stim_mem[base+8]),
			depth_bits(new_cfg.color_depth), cmd.color);
		plot = 1'b1;
		@(posedge clk);
		#1;
		plot = 1'b0;
	endtask

	// ================================================
	// main sequence
	// ================================================
	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		plot     = 1'b0;
		cmd      = '0;
		cfg      = '0;
		exp_wr   = '0;
		exp_drop = 1'b0;
		void'($urandom(77));
		// words not in the file keep a value above 1
		for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
			stim_mem[i] = 32'h8000_0000 | 32'(i);
		end
		$readmemh("plot_stim.txt", stim_mem);
		// rows end where the drop column stops holding 0 or 1
		n_lines = 0;
		while (n_lines < MAX_LINES && stim_mem[n_lines*FIELDS+9] <= 32'd1) begin
			n_lines++;
		end
		cycle_limit = 8 + n_lines * 8 + 100;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int ln = 0; ln < n_lines; ln++) begin
			apply_line(ln);
		end
		wait (idle == 1'b1);
		repeat (2) @(posedge clk);
		#1;
		if (n_lines == 0) begin
			$display("no commands were read from the stimulus file");
		end
		$display("commands %0d, writes checked %0d, drops %0d, errors %0d",
			n_lines, write_count, drop_total, err_count);
		if (err_count == 0 && n_lines > 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// run length guard
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("run still busy after %0d cycles, writes checked %0d, errors %0d",
				cycles, write_count, err_count);
			$display("Test failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: plot_stim.txt
// base depth hdisp vdisp x y color exp_addr exp_mb drop, all hex
// depth codes 0..7 are 6,8,9,12,15,16,24,32 bits per pixel
10000000 0 280 1e0 014 000 ffffffff 10000000 78 0
10000000 0 280 1e0 015 000 0000002a 10000010 00 0
10000000 0 280 1e0 029 002 12345675 100003f0 78 0
10000000 0 280 1e0 02a 002 00000015 10000400 00 0
10000000 0 280 1e0 280 000 00000001 00000000 00 1
00200000 1 100 010 00f 000 deadbeef 00200000 78 0
00200000 1 100 010 010 003 000000a5 00200310 00 0
00200000 1 100 010 0ff 00f ffffff3c 00200ff0 78 0
00200000 1 100 010 000 010 00000077 00000000 00 1
40000000 2 064 040 00d 001 ffffffff 40000080 75 0
40000000 2 064 040 00e 001 00000123 40000090 00 0
40000000 2 064 040 063 03f 0000fe01 40001ff0 09 0
00010000 3 050 020 009 002 abcdef12 00010100 6c 0
00010000 3 050 020 00a 002 00000fff 00010110 00 0
00300000 4 064 010 007 001 ffff8001 003000d0 69 0
00300000 4 064 010 008 001 00007abc 003000e0 00 0
00400000 5 040 008 007 007 ffffffff 00400380 70 0
00400000 5 040 008 008 007 0000beef 00400390 00 0
00500000 6 00b 004 004 001 ff123456 00500030 60 0
00500000 6 00b 004 005 001 00abcdef 00500040 00 0
00500000 6 00b 004 00a 003 ffffffff 005000b0 00 0
00500000 6 00b 004 00b 000 00000001 00000000 00 1
00600000 7 00e 002 003 001 89abcdef 00600040 60 0
00600000 7 00e 002 004 001 01234567 00600050 00 0
00600000 7 00e 002 00d 001 fedcba98 00600070 20 0

// File: project.f
gfx_pkg.sv
mem_pkg.sv
gfx_clip_stage.sv
gfx_calc_address.sv
gfx_strip_writer.sv
gfx_plot_unit.sv
tb_plot_checker.sv
tb_gfx_plot_unit.sv

// File: run_sim.sh
#!/bin/sh
# build the plot unit testbench with Verilator and run it
# the run passes only if the log holds the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir build.log sim.log &&
verilator --binary --timing -Wno-fatal --top-module tb_gfx_plot_unit \
	-f project.f -o sim_plot > build.log 2>&1 &&
./obj_dir/sim_plot > sim.log 2>&1 ;
grep -q "Test completed successfully" sim.log 2>/dev/null &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
